// ==== Bender.yml ====
package:
  name: bridge

sources:
  - design/bridge_pkg.sv
  - design/reset_sequencer.sv
  - design/cpu_index_tracker.sv
  - design/dispatch_token.sv
  - design/thread_msg_unit.sv
  - design/bridge_top.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/bridge_tb.sv

// ==== all.f ====
+incdir+tb
design/bridge_pkg.sv
design/reset_sequencer.sv
design/cpu_index_tracker.sv
design/dispatch_token.sv
design/thread_msg_unit.sv
design/bridge_top.sv
tb/bridge_tb.sv

// ==== design/bridge_pkg.sv ====
package bridge_pkg;

  // bus widths
  parameter int addr_width = 64;
  parameter int data_width = 32;
  parameter int msg_width  = 8;

  // cpu index layout
  // top bit flags a running thread, lower bits hold the ring position
  parameter int index_active_bit = 31;

  // core sequencer phases as seen by the bridge
  typedef enum logic [2:0] {
    // parked, waiting for a thread to be started
    wait_for_start = 3'd0,
    // thread entry, marks the own index active
    start_begin    = 3'd1,
    // operand and command fetch
    read_phase     = 3'd2,
    // result write back
    write_phase    = 3'd3,
    // execute
    alu_phase      = 3'd4,
    // thread exit, end message goes out here
    finish_begin   = 3'd5,
    // thread gone, local reset restarts
    finish_end     = 3'd6,
    idle           = 3'd7
  } core_phase_t;

  // ring message codes
  parameter logic [msg_width-1:0] msg_none  = 8'h00;
  // core came out of reset
  parameter logic [msg_width-1:0] msg_reset = 8'h01;
  // thread started on the sending core
  parameter logic [msg_width-1:0] msg_start = 8'h02;
  // thread ended on the sending core
  parameter logic [msg_width-1:0] msg_end   = 8'h03;

  // bus index position relative to own position
  typedef enum logic [1:0] {
    // no valid relation, token not on offer
    rel_none = 2'b00,
    // bus position below own position
    rel_lt   = 2'b01,
    // bus position above own position
    rel_gt   = 2'b10,
    // bus index is the own index
    rel_eq   = 2'b11
  } ind_rel_t;

endpackage

// ==== design/bridge_top.sv ====
`timescale 1ns/1ns

module bridge_top #(
  parameter int THREAD_HEADER_SPACE = 16
) (
  input  logic                                clk,
  input  logic                                ext_rst_b,
  // core side
  input  bridge_pkg::core_phase_t             phase,
  input  logic                                read_q,
  input  logic                                write_q,
  input  logic [bridge_pkg::addr_width-1:0]   addr_in,
  input  logic [bridge_pkg::data_width-1:0]   data_in,
  // ring side
  input  logic                                bus_busy,
  input  logic                                ext_next_cpu_q,
  input  logic [bridge_pkg::data_width-1:0]   ext_cpu_index,
  input  logic [bridge_pkg::msg_width-1:0]    ext_cpu_msg_in,
  // reset sequence
  output logic                                core_rst,
  output logic                                ext_rst_e,
  // token and dispatcher bus
  output logic                                ext_next_cpu_e,
  output logic                                ext_dispatcher_q,
  output logic                                ext_read_q,
  output logic                                ext_write_q,
  output logic                                disp_online,
  output bridge_pkg::ind_rel_t                cpu_ind_rel,
  // thread messages
  output logic                                next_state,
  output logic [bridge_pkg::msg_width-1:0]    ext_cpu_msg,
  output logic [bridge_pkg::addr_width-1:0]   base_addr,
  output logic [bridge_pkg::addr_width-1:0]   base_addr_data
);

  // sequencer to tracker and message unit
  logic seq_done;
  logic index_capture;
  logic index_clear;
  logic reset_msg;

  // tracker results
  bridge_pkg::ind_rel_t ind_rel;
  logic                 index_match;

  // token block to message unit
  logic launch_start;
  logic launch_end;

  reset_sequencer u_reset_sequencer (
    .clk              (clk),
    .ext_rst_b        (ext_rst_b),
    .phase            (phase),
    .bus_busy         (bus_busy),
    .seq_done         (seq_done),
    .index_capture    (index_capture),
    .index_clear      (index_clear),
    .reset_msg        (reset_msg),
    .core_rst         (core_rst),
    .ext_rst_e        (ext_rst_e),
    .ext_dispatcher_q (ext_dispatcher_q)
  );

  cpu_index_tracker u_cpu_index_tracker (
    .clk            (clk),
    .ext_rst_b      (ext_rst_b),
    .phase          (phase),
    .index_capture  (index_capture),
    .index_clear    (index_clear),
    .ext_cpu_index  (ext_cpu_index),
    .ext_cpu_msg_in (ext_cpu_msg_in),
    .own_index      (),
    .ind_rel        (ind_rel),
    .index_match    (index_match)
  );

  dispatch_token u_dispatch_token (
    .clk            (clk),
    .ext_rst_b      (ext_rst_b),
    .phase          (phase),
    .seq_done       (seq_done),
    .bus_busy       (bus_busy),
    .read_q         (read_q),
    .write_q        (write_q),
    .ext_next_cpu_q (ext_next_cpu_q),
    .index_match    (index_match),
    .ind_rel        (ind_rel),
    .ext_next_cpu_e (ext_next_cpu_e),
    .disp_online    (disp_online),
    .cpu_ind_rel    (cpu_ind_rel),
    .ext_read_q     (ext_read_q),
    .ext_write_q    (ext_write_q),
    .launch_start   (launch_start),
    .launch_end     (launch_end)
  );

  thread_msg_unit #(
    .THREAD_HEADER_SPACE (THREAD_HEADER_SPACE)
  ) u_thread_msg_unit (
    .clk            (clk),
    .ext_rst_b      (ext_rst_b),
    .reset_msg      (reset_msg),
    .launch_start   (launch_start),
    .launch_end     (launch_end),
    .addr_in        (addr_in),
    .data_in        (data_in),
    .ext_cpu_msg    (ext_cpu_msg),
    .base_addr      (base_addr),
    .base_addr_data (base_addr_data),
    .next_state     (next_state)
  );

endmodule

// ==== design/cpu_index_tracker.sv ====
`timescale 1ns/1ns

module cpu_index_tracker (
  input  logic                              clk,
  input  logic                              ext_rst_b,
  input  bridge_pkg::core_phase_t           phase,
  input  logic                              index_capture,
  input  logic                              index_clear,
  input  logic [bridge_pkg::data_width-1:0] ext_cpu_index,
  input  logic [bridge_pkg::msg_width-1:0]  ext_cpu_msg_in,
  output logic [bridge_pkg::data_width-1:0] own_index,
  output bridge_pkg::ind_rel_t              ind_rel,
  output logic                              index_match
);

  localparam int ab = bridge_pkg::index_active_bit;

  // split both indices into active flag and ring position
  logic          bus_active;
  logic          own_active;
  logic [ab-1:0] bus_pos;
  logic [ab-1:0] own_pos;

  assign bus_active  = ext_cpu_index[ab];
  assign own_active  = own_index[ab];
  assign bus_pos     = ext_cpu_index[ab-1:0];
  assign own_pos     = own_index[ab-1:0];
  assign index_match = (ext_cpu_index == own_index);

  // position compare, equal position with a different flag has no relation
  always_comb begin
    if (bus_pos < own_pos) begin
      ind_rel = bridge_pkg::rel_lt;
    end else if (bus_pos > own_pos) begin
      ind_rel = bridge_pkg::rel_gt;
    end else if (index_match) begin
      ind_rel = bridge_pkg::rel_eq;
    end else begin
      ind_rel = bridge_pkg::rel_none;
    end
  end

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      own_index <= '0;
    end else if (index_clear) begin
      own_index <= '0;
    end else if (index_capture) begin
      own_index <= ext_cpu_index;
    end else if (index_match) begin
      // first thread on position zero marks itself active
      if (own_index == '0 && phase == bridge_pkg::start_begin) begin
        own_index[ab] <= 1'b1;
      end
    end else if (bus_active) begin
      // a core ahead of us ended, we move down one slot
      if (ext_cpu_msg_in == bridge_pkg::msg_end && own_active && bus_pos < own_pos) begin
        own_index[ab-1:0] <= own_pos - 1'b1;
      end
    end else if (ext_cpu_msg_in == bridge_pkg::msg_start) begin
      // an idle core started a thread
      if (own_active) begin
        own_index[ab-1:0] <= own_pos + 1'b1;
      end else begin
        own_index[ab-1:0] <= own_pos - 1'b1;
      end
    end
  end

  a_capture_clear: assert property (@(posedge clk) disable iff (ext_rst_b)
    !(index_capture && index_clear));

endmodule

// ==== design/dispatch_token.sv ====
`timescale 1ns/1ns

module dispatch_token (
  input  logic                    clk,
  input  logic                    ext_rst_b,
  input  bridge_pkg::core_phase_t phase,
  input  logic                    seq_done,
  input  logic                    bus_busy,
  input  logic                    read_q,
  input  logic                    write_q,
  input  logic                    ext_next_cpu_q,
  input  logic                    index_match,
  input  bridge_pkg::ind_rel_t    ind_rel,
  output logic                    ext_next_cpu_e,
  output logic                    disp_online,
  output bridge_pkg::ind_rel_t    cpu_ind_rel,
  output logic                    ext_read_q,
  output logic                    ext_write_q,
  output logic                    launch_start,
  output logic                    launch_end
);

  // token offered to this core
  logic offer;
  logic core_req;
  // token taken on the coming edge
  logic grant;

  assign offer    = ext_next_cpu_q && index_match;
  assign core_req = read_q || write_q;
  assign grant    = seq_done && !bus_busy && offer;

  // launch strobes land in the message unit on the grant edge
  assign launch_start = grant && (phase == bridge_pkg::wait_for_start);
  assign launch_end   = grant && (phase == bridge_pkg::finish_begin);

  // core requests reach the dispatcher bus only while holding the token
  assign ext_read_q  = disp_online && (phase == bridge_pkg::read_phase) && read_q;
  assign ext_write_q = disp_online && (phase == bridge_pkg::write_phase) && write_q;

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      ext_next_cpu_e <= 1'b0;
      disp_online    <= 1'b0;
      cpu_ind_rel    <= bridge_pkg::rel_none;
    end else begin
      // relation seen on the ring is dropped once the token moves on
      if (ext_next_cpu_q) begin
        cpu_ind_rel <= ind_rel;
      end else if (ext_next_cpu_e) begin
        cpu_ind_rel <= bridge_pkg::rel_none;
      end

      if (!seq_done) begin
        // hand an offered token straight back during local reset
        ext_next_cpu_e <= offer;
        disp_online    <= 1'b0;
      end else if (bus_busy) begin
        // no pass and no grant under back-pressure
        ext_next_cpu_e <= 1'b0;
      end else begin
        // go offline once the token is passed and the core is quiet
        if (disp_online && ext_next_cpu_e && !core_req) begin
          disp_online <= 1'b0;
        end
        if (grant) begin
          disp_online <= 1'b1;
        end
        // start and end messages pass the token straight on
        // other phases keep it for bus access
        ext_next_cpu_e <= launch_start || launch_end;
      end
    end
  end

  a_rw_exclusive: assert property (@(posedge clk) disable iff (ext_rst_b)
    !(ext_read_q && ext_write_q));

endmodule

// ==== design/reset_sequencer.sv ====
`timescale 1ns/1ns

module reset_sequencer (
  input  logic                    clk,
  input  logic                    ext_rst_b,
  input  bridge_pkg::core_phase_t phase,
  input  logic                    bus_busy,
  output logic                    seq_done,
  output logic                    index_capture,
  output logic                    index_clear,
  output logic                    reset_msg,
  output logic                    core_rst,
  output logic                    ext_rst_e,
  output logic                    ext_dispatcher_q
);

  // local reset step, 0 to 4, parked at 4 once done
  logic [2:0] step;
  logic       restart;

  // thread finished, run the local reset again without the index load
  assign restart = seq_done && (phase == bridge_pkg::finish_end) && !bus_busy;
  assign index_clear = restart;

  // step 2 loads the ring index and announces the reset
  assign index_capture = (step == 3'd2) && !bus_busy;
  assign reset_msg     = (step == 3'd2) && !bus_busy;

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      step             <= 3'd0;
      seq_done         <= 1'b0;
      core_rst         <= 1'b0;
      ext_rst_e        <= 1'b0;
      ext_dispatcher_q <= 1'b0;
    end else begin
      // reset strobes are single cycle
      core_rst  <= 1'b0;
      ext_rst_e <= 1'b0;
      if (restart) begin
        step     <= 3'd0;
        seq_done <= 1'b0;
      end else if (!seq_done && !bus_busy) begin
        case (step)
          3'd0: begin
            // drop off the dispatcher while resetting
            ext_dispatcher_q <= 1'b0;
            step             <= 3'd1;
          end
          3'd1: begin
            // restart after a thread keeps the tracked index
            if (phase == bridge_pkg::finish_end) begin
              step <= 3'd3;
            end else begin
              step <= 3'd2;
            end
          end
          3'd2: begin
            step <= 3'd3;
          end
          3'd3: begin
            core_rst <= 1'b1;
            // ring reset only on a cold start
            ext_rst_e <= (phase != bridge_pkg::finish_end);
            step      <= 3'd4;
          end
          default: begin
            ext_dispatcher_q <= 1'b1;
            seq_done         <= 1'b1;
          end
        endcase
      end
    end
  end

  a_core_rst_pulse: assert property (@(posedge clk) disable iff (ext_rst_b)
    core_rst |=> !core_rst);

endmodule

// ==== design/thread_msg_unit.sv ====
`timescale 1ns/1ns

module thread_msg_unit #(
  parameter int THREAD_HEADER_SPACE = 16
) (
  input  logic                              clk,
  input  logic                              ext_rst_b,
  input  logic                              reset_msg,
  input  logic                              launch_start,
  input  logic                              launch_end,
  input  logic [bridge_pkg::addr_width-1:0] addr_in,
  input  logic [bridge_pkg::data_width-1:0] data_in,
  output logic [bridge_pkg::msg_width-1:0]  ext_cpu_msg,
  output logic [bridge_pkg::addr_width-1:0] base_addr,
  output logic [bridge_pkg::addr_width-1:0] base_addr_data,
  output logic                              next_state
);

  localparam int aw = bridge_pkg::addr_width;
  localparam int dw = bridge_pkg::data_width;

  // thread header skipped in front of code and data
  localparam logic [aw-1:0] hdr_space = THREAD_HEADER_SPACE;

  logic [aw-1:0] code_base;
  logic [aw-1:0] data_base;

  assign code_base = addr_in + hdr_space;
  // zero data pointer means data shares the code block
  assign data_base = (data_in == '0) ? code_base : {{(aw - dw){1'b0}}, data_in} + hdr_space;

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      ext_cpu_msg    <= bridge_pkg::msg_none;
      base_addr      <= '0;
      base_addr_data <= '0;
      next_state     <= 1'b0;
    end else begin
      // message on the ring for one cycle only
      if (reset_msg) begin
        ext_cpu_msg <= bridge_pkg::msg_reset;
      end else if (launch_start) begin
        ext_cpu_msg <= bridge_pkg::msg_start;
      end else if (launch_end) begin
        ext_cpu_msg <= bridge_pkg::msg_end;
      end else begin
        ext_cpu_msg <= bridge_pkg::msg_none;
      end

      // core steps on together with the start message
      next_state <= launch_start;

      // bases kept for the life of the thread
      if (launch_start) begin
        base_addr      <= code_base;
        base_addr_data <= data_base;
      end
    end
  end

  // sequencer and token block never fire in the same cycle
  a_one_trigger: assert property (@(posedge clk) disable iff (ext_rst_b)
    $onehot0({reset_msg, launch_start, launch_end}));

endmodule

// ==== tb/bridge_model.svh ====
// expected state of the bridge, reset values
logic [31:0]          m_own = '0;
bridge_pkg::ind_rel_t m_rel = bridge_pkg::rel_none;
logic [7:0]           m_msg = bridge_pkg::msg_none;
logic                 m_online = 1'b0;
logic                 m_e = 1'b0;
logic                 m_next = 1'b0;
logic [63:0]          m_base = '0;
logic [63:0]          m_base_data = '0;

// bit 31 is the active flag, 30:0 the ring position
function automatic bridge_pkg::ind_rel_t rel_of(input logic [31:0] bus, input logic [31:0] own);
  if (bus[30:0] < own[30:0]) return bridge_pkg::rel_lt;
  if (bus[30:0] > own[30:0]) return bridge_pkg::rel_gt;
  // same slot but other flag means no relation
  return (bus == own) ? bridge_pkg::rel_eq : bridge_pkg::rel_none;
endfunction

function automatic logic [31:0] next_own(input logic [31:0] own, input logic [31:0] bus,
                                         input logic [7:0] msg, input bridge_pkg::core_phase_t ph);
  logic [31:0] n;
  n = own;
  if (bus == own) begin
    // first thread in slot zero goes active
    if (own == '0 && ph == bridge_pkg::start_begin) n[31] = 1'b1;
  end else if (bus[31]) begin
    if (msg == bridge_pkg::msg_end && own[31] && bus[30:0] < own[30:0]) n[30:0] = own[30:0] - 1;
  end else if (msg == bridge_pkg::msg_start) begin
    n[30:0] = own[31] ? own[30:0] + 1 : own[30:0] - 1;
  end
  return n;
endfunction

function automatic logic [63:0] code_base(input logic [63:0] addr);
  return addr + hdr_space;
endfunction

// zero data pointer shares the code block
function automatic logic [63:0] data_base(input logic [63:0] addr, input logic [31:0] data);
  if (data == '0) return code_base(addr);
  return {32'd0, data} + hdr_space;
endfunction

// advance the model by one edge from the inputs currently driven
task automatic model_step(input logic cap, input logic clr, input logic done);
  logic offer;
  logic grant;
  logic start_go;
  logic end_go;
  offer    = ext_next_cpu_q && (ext_cpu_index == m_own);
  grant    = done && !bus_busy && offer;
  start_go = grant && phase == bridge_pkg::wait_for_start;
  end_go   = grant && phase == bridge_pkg::finish_begin;
  if (ext_next_cpu_q) m_rel = rel_of(ext_cpu_index, m_own);
  else if (m_e) m_rel = bridge_pkg::rel_none;
  if (cap) m_msg = bridge_pkg::msg_reset;
  else if (start_go) m_msg = bridge_pkg::msg_start;
  else if (end_go) m_msg = bridge_pkg::msg_end;
  else m_msg = bridge_pkg::msg_none;
  m_next = start_go;
  if (start_go) begin
    m_base      = code_base(addr_in);
    m_base_data = data_base(addr_in, data_in);
  end
  // token: bounce while in local reset, hold under back-pressure
  if (!done) begin
    m_online = 1'b0;
    m_e      = offer;
  end else if (bus_busy) begin
    m_e = 1'b0;
  end else begin
    if (m_online && m_e && !(read_q || write_q)) m_online = 1'b0;
    if (grant) m_online = 1'b1;
    m_e = start_go || end_go;
  end
  if (clr) m_own = '0;
  else if (cap) m_own = ext_cpu_index;
  else m_own = next_own(m_own, ext_cpu_index, ext_cpu_msg_in, phase);
endtask

// ==== tb/bridge_tb.sv ====
`timescale 1ns/1ns

module bridge_tb;

  localparam int hdr_space = 16;
  // 300 ring cycles and two thread lifetimes fit well below this
  localparam int max_cycles = 4000;

  logic clk = 1'b0;
  logic ext_rst_b;
  logic read_q;
  logic write_q;
  logic bus_busy;
  logic ext_next_cpu_q;
  bridge_pkg::core_phase_t phase;
  logic [63:0] addr_in;
  logic [31:0] data_in;
  logic [31:0] ext_cpu_index;
  logic [7:0]  ext_cpu_msg_in;
  logic [7:0]  ext_cpu_msg;
  logic core_rst;
  logic ext_rst_e;
  logic ext_next_cpu_e;
  logic ext_dispatcher_q;
  logic ext_read_q;
  logic ext_write_q;
  logic next_state;
  logic disp_online;
  bridge_pkg::ind_rel_t cpu_ind_rel;
  logic [63:0] base_addr;
  logic [63:0] base_addr_data;
  logic [31:0] rng_state = 32'h23be;
  // sequencer finished as the token block sees it
  logic seq_up = 1'b0;

  `include "bridge_model.svh"

  bridge_top #(.THREAD_HEADER_SPACE(hdr_space)) u_dut (.*);

  always #4 clk = ~clk;

  initial begin
    int cycles;
    cycles = 0;
    while (cycles < max_cycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("run stopped, no end reached after %0d cycles", cycles);
    $display("Done: errors found");
    $fatal(1, "timeout");
  end

  function automatic logic [31:0] xorshift();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("Done: errors found");
      $fatal(1, "check failed");
    end
  endtask

  // one clock with the model stepped first and the registered outputs compared after
  task automatic tick(input logic cap, input logic clr);
    model_step(cap, clr, seq_up);
    @(posedge clk);
    #1;
    check("ext_cpu_msg", ext_cpu_msg, m_msg);
    check("cpu_ind_rel", cpu_ind_rel, m_rel);
    check("disp_online", disp_online, m_online);
    check("ext_next_cpu_e", ext_next_cpu_e, m_e);
    check("next_state", next_state, m_next);
    check("base_addr", base_addr, m_base);
    check("base_addr_data", base_addr_data, m_base_data);
  endtask

  // warm restart skips index load, reset message and ring reset
  task automatic local_reset(input logic warm);
    if (warm) begin
      phase = bridge_pkg::finish_end;
      tick(1'b0, 1'b1);
      seq_up = 1'b0;
    end
    tick(1'b0, 1'b0);
    check("ext_dispatcher_q", ext_dispatcher_q, 1'b0);
    tick(1'b0, 1'b0);
    if (!warm) tick(1'b1, 1'b0);
    tick(1'b0, 1'b0);
    check("core_rst", core_rst, 1'b1);
    check("ext_rst_e", ext_rst_e, !warm);
    phase = bridge_pkg::idle;
    tick(1'b0, 1'b0);
    seq_up = 1'b1;
    check("core_rst", core_rst, 1'b0);
    check("ext_dispatcher_q", ext_dispatcher_q, 1'b1);
  endtask

  // start and end broadcasts from other cores on small positions
  task automatic random_ring(input int n);
    logic [31:0] r;
    repeat (n) begin
      r = xorshift();
      ext_cpu_index  = {r[31], 26'd0, r[4:0]};
      ext_next_cpu_q = r[12] | r[13];
      bus_busy       = r[16] & r[17];
      case (r[9:8])
        2'd0: ext_cpu_msg_in = bridge_pkg::msg_none;
        2'd1: ext_cpu_msg_in = bridge_pkg::msg_reset;
        2'd2: ext_cpu_msg_in = bridge_pkg::msg_start;
        default: ext_cpu_msg_in = bridge_pkg::msg_end;
      endcase
      tick(1'b0, 1'b0);
    end
    ext_next_cpu_q = 1'b0;
    bus_busy       = 1'b0;
    ext_cpu_msg_in = bridge_pkg::msg_none;
  endtask

  task automatic thread_start(input logic zero_data);
    phase          = bridge_pkg::wait_for_start;
    addr_in        = {xorshift(), xorshift()};
    data_in        = zero_data ? 32'd0 : xorshift();
    ext_cpu_index  = m_own;
    ext_next_cpu_q = 1'b1;
    tick(1'b0, 1'b0);
    check("ext_cpu_msg", ext_cpu_msg, bridge_pkg::msg_start);
    check("next_state", next_state, 1'b1);
    check("ext_next_cpu_e", ext_next_cpu_e, 1'b1);
    ext_next_cpu_q = 1'b0;
    phase          = bridge_pkg::idle;
    // token gone and core quiet so the bridge drops offline
    tick(1'b0, 1'b0);
  endtask

  task automatic gate_run(input int n);
    logic [31:0] r;
    repeat (n) begin
      r       = xorshift();
      read_q  = r[0];
      write_q = r[1];
      if (r[5:4] == 2'd3) begin
        phase = bridge_pkg::idle;
      end else begin
        phase = bridge_pkg::core_phase_t'(3'd2 + {1'b0, r[5:4]});
      end
      #1;
      check("ext_read_q", ext_read_q, m_online && phase == bridge_pkg::read_phase && read_q);
      check("ext_write_q", ext_write_q, m_online && phase == bridge_pkg::write_phase && write_q);
      tick(1'b0, 1'b0);
    end
    read_q  = 1'b0;
    write_q = 1'b0;
    phase   = bridge_pkg::idle;
  endtask

  initial begin
    ext_rst_b      = 1'b1;
    phase          = bridge_pkg::idle;
    read_q         = 1'b0;
    write_q        = 1'b0;
    bus_busy       = 1'b0;
    ext_next_cpu_q = 1'b0;
    addr_in        = '0;
    data_in        = '0;
    ext_cpu_msg_in = bridge_pkg::msg_none;
    // ring slot picked up by the cold reset
    ext_cpu_index  = (xorshift() & 32'h1f) | 32'd1;
    repeat (8) @(posedge clk);
    #1;
    ext_rst_b = 1'b0;
    local_reset(1'b0);
    random_ring(150);
    thread_start(1'b0);
    thread_start(1'b1);
    gate_run(20);
    // take the token in read_phase and keep it
    phase          = bridge_pkg::read_phase;
    ext_cpu_index  = m_own;
    ext_next_cpu_q = 1'b1;
    tick(1'b0, 1'b0);
    ext_next_cpu_q = 1'b0;
    gate_run(60);
    // back-pressure holds off the start message
    bus_busy       = 1'b1;
    phase          = bridge_pkg::wait_for_start;
    ext_cpu_index  = m_own;
    ext_next_cpu_q = 1'b1;
    repeat (6) begin
      tick(1'b0, 1'b0);
      check("ext_cpu_msg", ext_cpu_msg, bridge_pkg::msg_none);
    end
    bus_busy = 1'b0;
    phase    = bridge_pkg::finish_begin;
    tick(1'b0, 1'b0);
    check("ext_cpu_msg", ext_cpu_msg, bridge_pkg::msg_end);
    ext_next_cpu_q = 1'b0;
    phase          = bridge_pkg::idle;
    tick(1'b0, 1'b0);
    local_reset(1'b1);
    // second thread from slot zero goes active in start_begin
    thread_start(1'b1);
    phase         = bridge_pkg::start_begin;
    ext_cpu_index = m_own;
    tick(1'b0, 1'b0);
    phase = bridge_pkg::idle;
    random_ring(150);
    $display("Done: no errors");
    $finish;
  end

endmodule
